// File: build.f
shotPkg.sv
shotStepDecode.sv
shotMotion.sv
shotLifeCycle.sv
shotSubsystem.sv
shotModel.sv
shotTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the shot subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module shotTb \
  -f build.f \
  -o shotSim

./obj_dir/shotSim | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: shotLifeCycle.sv
module shotLifeCycle (
  input  logic                                clk,
  input  logic                                resetN,
  input  logic                                triggerShot,
  input  logic                                boxHit,
  input  logic                                enemyHit,
  input  logic                                dragonHit,
  input  logic                                frameStep,
  input  logic                                nextOut,
  input  logic signed [shotPkg::fixWidth-1:0] posFixX,
  input  logic signed [shotPkg::fixWidth-1:0] posFixY,
  output logic                                launch,
  output logic                                retire,
  output logic                                live,
  output logic                                ready,
  output logic signed [shotPkg::posWidth-1:0] shotX,
  output logic signed [shotPkg::posWidth-1:0] shotY
);
  import shotPkg::*;

  logic anyHit;
  logic edgeExit;

  assign anyHit = boxHit || enemyHit || dragonHit;
  assign edgeExit = frameStep && nextOut;   // frameStep already implies live

  // a trigger during flight is dropped, there is no back-pressure
  assign launch = triggerShot && !live;

  // hits count even while paused and win over a frame step
  assign retire = live && (anyHit || edgeExit);

  assign ready = !live;

  // one shot at a time
  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      live <= 1'b0;
    end else if (launch) begin
      live <= 1'b1;
    end else if (retire) begin
      live <= 1'b0;
    end
  end

  // pixel coordinates, signed divide truncates toward zero
  // a parked shot reads as the off-screen location
  always_comb begin
    shotX = posWidth'(posFixX / fixedScale);
    shotY = posWidth'(posFixY / fixedScale);
  end

endmodule

// File: shotModel.sv
module shotModel #(
  parameter int straightSpeed = 100,
  parameter int lateralSpeed = 30,
  parameter int angledSpeed = 70,
  parameter int puStraightSpeed = 170,
  parameter int puLateralSpeed = 50,
  parameter int puAngledSpeed = 110
) (
  input  logic              clk,
  input  logic              resetN,
  input  logic              triggerShot,
  input  logic              startOfFrame,
  input  logic              pause,
  input  logic              boxHit,
  input  logic              enemyHit,
  input  logic              dragonHit,
  input  logic [2:0]        shotDirection,
  input  logic              poweredUp,
  input  logic signed [10:0] playerX,
  input  logic signed [10:0] playerY,
  input  logic              ready,
  input  logic signed [10:0] shotX,
  input  logic signed [10:0] shotY,
  input  logic [2:0]        shotDir,
  output int                errorCount
);
  timeunit 1ns;
  timeprecision 100ps;
  import shotPkg::*;

  typedef struct packed {
    logic       live;
    logic       power;
    logic [2:0] dir;
    int         posX;   // fixed-point units
    int         posY;
  } shotState;

  shotState state;
  int mismatches = 0;

  assign errorCount = mismatches;

  function automatic shotState parkedState();
    shotState p;
    p.live = 1'b0;
    p.power = 1'b0;
    p.dir = 3'b000;
    p.posX = offScreenFix;
    p.posY = offScreenFix;
    return p;
  endfunction

  // next model state from the current state and the inputs of one clock
  function automatic shotState nextState(input shotState cur, input logic trig,
                                         input logic frame, input logic hold,
                                         input logic hit, input logic [2:0] dirIn,
                                         input logic pwrIn, input int px, input int py);
    shotState nxt;
    int xs;
    int ys;
    int nx;
    int ny;
    nxt = cur;
    case (cur.dir)
      3'b100: begin
        xs = cur.power ? -puLateralSpeed : -lateralSpeed;
        ys = cur.power ? puAngledSpeed : angledSpeed;
      end
      3'b001: begin
        xs = cur.power ? puLateralSpeed : lateralSpeed;
        ys = cur.power ? puAngledSpeed : angledSpeed;
      end
      default: begin
        xs = 0;   // up, and every unknown code
        ys = cur.power ? puStraightSpeed : straightSpeed;
      end
    endcase
    nx = cur.posX + xs;
    ny = cur.posY - ys;
    if (!cur.live) begin
      if (trig) begin
        nxt.live = 1'b1;
        nxt.power = pwrIn;
        nxt.dir = dirIn;
        nxt.posX = px * fixedScale;
        nxt.posY = py * fixedScale;
      end
    end else if (hit) begin
      nxt = parkedState();   // hit wins, pause or not
    end else if (frame && !hold) begin
      if (ny < topLimitFix || nx < leftLimitFix || nx > rightLimitFix) nxt = parkedState();
      else begin
        nxt.posX = nx;
        nxt.posY = ny;
      end
    end
    return nxt;
  endfunction

  always @(posedge clk or negedge resetN) begin
    if (!resetN) state <= parkedState();
    else state <= nextState(state, triggerShot, startOfFrame, pause,
                            boxHit || enemyHit || dragonHit, shotDirection,
                            poweredUp, int'(playerX), int'(playerY));
  end

  task automatic reportMismatch(input string name, input int got, input int exp);
    mismatches++;
    $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
  endtask

  // outputs settle after the rising edge, compare in the middle of the cycle
  always @(negedge clk) begin
    assert (int'(ready) == int'(!state.live))
      else reportMismatch("ready", int'(ready), int'(!state.live));
    assert (int'(shotX) == state.posX / fixedScale)
      else reportMismatch("shotX", int'(shotX), state.posX / fixedScale);
    assert (int'(shotY) == state.posY / fixedScale)
      else reportMismatch("shotY", int'(shotY), state.posY / fixedScale);
    assert (shotDir == state.dir)
      else reportMismatch("shotDir", int'(shotDir), int'(state.dir));
  end

endmodule

// File: shotMotion.sv
module shotMotion (
  input  logic                                clk,
  input  logic                                resetN,
  input  logic                                launch,
  input  logic                                retire,
  input  logic                                live,
  input  logic                                startOfFrame,
  input  logic                                pause,
  input  logic signed [shotPkg::posWidth-1:0] playerX,
  input  logic signed [shotPkg::posWidth-1:0] playerY,
  input  logic signed [shotPkg::fixWidth-1:0] xStep,
  input  logic        [shotPkg::fixWidth-2:0] yStep,
  output logic signed [shotPkg::fixWidth-1:0] posFixX,
  output logic signed [shotPkg::fixWidth-1:0] posFixY,
  output logic                                nextOut,
  output logic                                frameStep
);
  import shotPkg::*;

  logic signed [fixWidth-1:0] nextX;
  logic signed [fixWidth-1:0] nextY;
  logic signed [fixWidth-1:0] yStepS;   // yStep widened to a signed word

  // one move per unpaused frame, only while a shot is in flight
  assign frameStep = startOfFrame && !pause && live && !launch;

  // candidate position for this frame
  always_comb begin
    yStepS = $signed({1'b0, yStep});
    nextX = posFixX + xStep;
    nextY = posFixY - yStepS;   // screen Y grows downward, the shot climbs
  end

  // the step would cross the top, left or right limit
  assign nextOut = (nextY < topLimitFix) ||
                   (nextX < leftLimitFix) ||
                   (nextX > rightLimitFix);

  // position register
  // an exiting step is not taken here, retire parks the shot a cycle later
  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      posFixX <= fixWidth'(offScreenFix);
      posFixY <= fixWidth'(offScreenFix);
    end else if (launch) begin
      posFixX <= fixWidth'(playerX * fixedScale);   // leave from player corner
      posFixY <= fixWidth'(playerY * fixedScale);
    end else if (retire) begin
      posFixX <= fixWidth'(offScreenFix);
      posFixY <= fixWidth'(offScreenFix);
    end else if (frameStep && !nextOut) begin
      posFixX <= nextX;
      posFixY <= nextY;
    end
  end

endmodule

// File: shotPkg.sv
package shotPkg;

  // fixed point: the position is kept in 1/64 pixel units
  localparam int fixedScale = 64;         // units per pixel
  localparam int posWidth = 11;           // signed pixel coordinate width
  localparam int fixWidth = 20;           // signed fixed-point position width

  // legal flight area, in fixed-point units
  localparam int topLimitFix = 100;       // smallest legal Y
  localparam int leftLimitFix = 40;       // smallest legal X
  localparam int rightLimitFix = 40900;   // largest legal X, about 639 px

  // parked location of an idle shot
  localparam int offScreenFix = 50000;
  localparam int offScreenPix = offScreenFix / fixedScale;  // 781 px

  // one-hot fire directions, any other code flies straight up
  localparam logic [2:0] dirLeft = 3'b100;
  localparam logic [2:0] dirUp = 3'b010;
  localparam logic [2:0] dirRight = 3'b001;

endpackage

// File: shotStepDecode.sv
module shotStepDecode #(
  parameter int straightSpeed = 100,
  parameter int lateralSpeed = 30,
  parameter int angledSpeed = 70,
  parameter int puStraightSpeed = 170,
  parameter int puLateralSpeed = 50,
  parameter int puAngledSpeed = 110
) (
  input  logic                                clk,
  input  logic                                resetN,
  input  logic                                launch,
  input  logic                                retire,
  input  logic [2:0]                          shotDirection,
  input  logic                                poweredUp,
  output logic signed [shotPkg::fixWidth-1:0] xStep,
  output logic        [shotPkg::fixWidth-2:0] yStep,
  output logic [2:0]                          shotDir
);
  import shotPkg::*;

  logic powerReg;   // power state held for the whole flight
  int curStraight;
  int curLateral;
  int curAngled;

  // latch direction and power at launch, direction drops when the shot retires
  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      shotDir <= 3'b000;
      powerReg <= 1'b0;
    end else if (launch) begin
      shotDir <= shotDirection;
      powerReg <= poweredUp;
    end else if (retire) begin
      shotDir <= 3'b000;
    end
  end

  // speed set follows the latched power state
  always_comb begin
    curStraight = powerReg ? puStraightSpeed : straightSpeed;
    curLateral = powerReg ? puLateralSpeed : lateralSpeed;
    curAngled = powerReg ? puAngledSpeed : angledSpeed;
  end

  always_comb begin
    case (shotDir)
      dirLeft: begin
        xStep = fixWidth'(-curLateral);      // drifts left
        yStep = (fixWidth-1)'(curAngled);
      end
      dirRight: begin
        xStep = fixWidth'(curLateral);
        yStep = (fixWidth-1)'(curAngled);
      end
      default: begin   // up, and any other code
        xStep = '0;
        yStep = (fixWidth-1)'(curStraight);  // straight up, full speed
      end
    endcase
  end

endmodule

// File: shotSubsystem.sv
module shotSubsystem #(
  parameter int straightSpeed = 100,
  parameter int lateralSpeed = 30,
  parameter int angledSpeed = 70,
  parameter int puStraightSpeed = 170,
  parameter int puLateralSpeed = 50,
  parameter int puAngledSpeed = 110
) (
  input  logic                                clk,
  input  logic                                resetN,
  input  logic                                startOfFrame,  // once per frame
  input  logic                                triggerShot,
  input  logic [2:0]                          shotDirection,
  input  logic                                poweredUp,
  input  logic                                pause,
  input  logic                                boxHit,
  input  logic                                enemyHit,
  input  logic                                dragonHit,
  input  logic signed [shotPkg::posWidth-1:0] playerX,
  input  logic signed [shotPkg::posWidth-1:0] playerY,
  output logic                                ready,
  output logic signed [shotPkg::posWidth-1:0] shotX,
  output logic signed [shotPkg::posWidth-1:0] shotY,
  output logic [2:0]                          shotDir
);
  import shotPkg::*;

  logic launch;
  logic retire;
  logic live;
  logic nextOut;
  logic frameStep;
  logic signed [fixWidth-1:0] xStep;
  logic        [fixWidth-2:0] yStep;
  logic signed [fixWidth-1:0] posFixX;
  logic signed [fixWidth-1:0] posFixY;

  // decode: direction and power into per-frame steps
  shotStepDecode #(
    .straightSpeed   (straightSpeed),
    .lateralSpeed    (lateralSpeed),
    .angledSpeed     (angledSpeed),
    .puStraightSpeed (puStraightSpeed),
    .puLateralSpeed  (puLateralSpeed),
    .puAngledSpeed   (puAngledSpeed)
  ) decode (
    .clk, .resetN, .launch, .retire, .shotDirection, .poweredUp,
    .xStep, .yStep, .shotDir
  );

  // execute: fixed-point position
  shotMotion motion (
    .clk, .resetN, .launch, .retire, .live, .startOfFrame, .pause,
    .playerX, .playerY, .xStep, .yStep,
    .posFixX, .posFixY, .nextOut, .frameStep
  );

  // result: life cycle and pixel outputs
  shotLifeCycle lifeCycle (
    .clk, .resetN, .triggerShot, .boxHit, .enemyHit, .dragonHit,
    .frameStep, .nextOut, .posFixX, .posFixY,
    .launch, .retire, .live, .ready, .shotX, .shotY
  );

endmodule

// File: shotTb.sv
module shotTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int straightSpeed = 100;
  localparam int lateralSpeed = 30;
  localparam int angledSpeed = 70;
  localparam int puStraightSpeed = 170;
  localparam int puLateralSpeed = 50;
  localparam int puAngledSpeed = 110;
  localparam int numTests = 24;
  localparam int frameCycles = 20;
  localparam int watchdogNs = numTests * 60 * frameCycles * 4 + 2000;

  logic clk;
  logic resetN;
  logic startOfFrame;
  logic triggerShot;
  logic [2:0] shotDirection;
  logic poweredUp;
  logic pause;
  logic boxHit;
  logic enemyHit;
  logic dragonHit;
  logic signed [10:0] playerX;
  logic signed [10:0] playerY;
  logic ready;
  logic signed [10:0] shotX;
  logic signed [10:0] shotY;
  logic [2:0] shotDir;
  int tbErrors = 0;
  int modelErrors;
  int frameTick;
  logic [2:0] dirCodes [5] = '{3'b100, 3'b010, 3'b001, 3'b000, 3'b111};

  shotSubsystem #(
    .straightSpeed(straightSpeed), .lateralSpeed(lateralSpeed), .angledSpeed(angledSpeed),
    .puStraightSpeed(puStraightSpeed), .puLateralSpeed(puLateralSpeed),
    .puAngledSpeed(puAngledSpeed)
  ) DUT (
    .clk, .resetN, .startOfFrame, .triggerShot, .shotDirection, .poweredUp, .pause,
    .boxHit, .enemyHit, .dragonHit, .playerX, .playerY, .ready, .shotX, .shotY, .shotDir
  );

  shotModel #(
    .straightSpeed(straightSpeed), .lateralSpeed(lateralSpeed), .angledSpeed(angledSpeed),
    .puStraightSpeed(puStraightSpeed), .puLateralSpeed(puLateralSpeed),
    .puAngledSpeed(puAngledSpeed)
  ) model (
    .clk, .resetN, .triggerShot, .startOfFrame, .pause, .boxHit, .enemyHit, .dragonHit,
    .shotDirection, .poweredUp, .playerX, .playerY, .ready, .shotX, .shotY, .shotDir,
    .errorCount(modelErrors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // frame strobe, one cycle in every frameCycles
  initial begin
    startOfFrame = 1'b0;
    frameTick = 0;
    forever begin
      @(posedge clk);
      #1;
      startOfFrame = (frameTick == frameCycles - 1);
      frameTick = (frameTick + 1) % frameCycles;
    end
  end

  initial begin
    #(watchdogNs);
    $display("timeout: the tests did not finish within %0d ns", watchdogNs);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic waitCycles(input int n);
    repeat (n) nextCycle();
  endtask

  // returns just after the edge that sampled a frame strobe
  task automatic waitFrames(input int n);
    repeat (n) begin
      @(posedge clk);
      while (!startOfFrame) @(posedge clk);
    end
    #1;
  endtask

  task automatic checkValue(input string name, input int got, input int exp);
    assert (got == exp) else begin
      tbErrors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic pulseHit(input int kind);
    case (kind)
      0: boxHit = 1'b1;
      1: enemyHit = 1'b1;
      default: dragonHit = 1'b1;
    endcase
    nextCycle();
    boxHit = 1'b0;
    enemyHit = 1'b0;
    dragonHit = 1'b0;
  endtask

  task automatic fireShot(input logic [2:0] dir, input logic pwr, input int x, input int y);
    shotDirection = dir;
    poweredUp = pwr;
    playerX = 11'(x);
    playerY = 11'(y);
    triggerShot = 1'b1;
    nextCycle();
    triggerShot = 1'b0;
    checkValue("ready", int'(ready), 0);   // shot leaves from the player corner
    checkValue("shotX", int'(shotX), x);
    checkValue("shotY", int'(shotY), y);
  endtask

  task automatic waitRetire(input int limitCycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!ready && n < limitCycles) begin
      @(negedge clk);
      n++;
    end
    assert (ready) else begin
      tbErrors++;
      $display("shot still in flight after %0d cycles", limitCycles);
    end
    nextCycle();
    checkValue("shotDir", int'(shotDir), 0);
    checkValue("shotX", int'(shotX), 781);
    checkValue("shotY", int'(shotY), 781);
  endtask

  initial begin
    logic [2:0] dir;
    logic pwr;
    int x;
    int y;
    int mode;
    void'($urandom(32'h1ef6));
    resetN = 1'b0;
    triggerShot = 1'b0;
    shotDirection = 3'b000;
    poweredUp = 1'b0;
    pause = 1'b0;
    boxHit = 1'b0;
    enemyHit = 1'b0;
    dragonHit = 1'b0;
    playerX = '0;
    playerY = '0;
    waitCycles(16);
    resetN = 1'b1;
    nextCycle();
    checkValue("ready", int'(ready), 1);
    checkValue("shotX", int'(shotX), 781);
    checkValue("shotY", int'(shotY), 781);
    checkValue("shotDir", int'(shotDir), 0);
    for (int t = 0; t < numTests; t++) begin
      dir = dirCodes[t % 5];
      pwr = (t < 10) ? (t >= 5) : 1'($urandom_range(1, 0));
      mode = t % 3;   // 0 edge, 1 hit, 2 pause window
      // start points leave at least ten frames of flight at full power
      case (dir)
        3'b100: begin x = $urandom_range(20, 12); y = $urandom_range(470, 200); end
        3'b001: begin x = $urandom_range(630, 620); y = $urandom_range(470, 200); end
        default: begin x = $urandom_range(630, 10); y = $urandom_range(55, 28); end
      endcase
      fireShot(dir, pwr, x, y);
      waitFrames(1);
      waitCycles($urandom_range(6, 1));
      shotDirection = ~dir;   // trigger during flight must be dropped
      poweredUp = !pwr;
      triggerShot = 1'b1;
      nextCycle();
      triggerShot = 1'b0;
      if (mode == 2) begin
        waitFrames($urandom_range(3, 1));
        pause = 1'b1;
        waitFrames($urandom_range(3, 2));
        if ((t / 3) % 2 == 1) begin   // every other pause window ends in a hit
          waitCycles($urandom_range(15, 0));
          pulseHit((t / 3) % 3);
        end
        waitFrames(1);
        pause = 1'b0;
      end else if (mode == 1) begin
        waitFrames($urandom_range(8, 1));
        waitCycles($urandom_range(18, 0));
        pulseHit((t / 3) % 3);
      end
      waitRetire(65 * frameCycles);
      waitCycles($urandom_range(30, 1));
    end
    $display("errors: testbench checks %0d, model compare %0d", tbErrors, modelErrors);
    if (tbErrors + modelErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
